//--- bp_pkg.sv
package bp_pkg;

	////////////////////
	// table geometry
	////////////////////

	// word program counter width
	localparam int PC_W  = 10;
	// set index comes from the low pc bits
	localparam int SET_W = 4;
	// tag is whatever is left above the set bits
	localparam int TAG_W = PC_W - SET_W;
	localparam int WAYS  = 4;
	localparam int WAY_W = 2;
	localparam int SETS  = 16;

	// 2-bit saturating counter, msb is the taken prediction
	localparam int CTR_W = 2;
	// branches start weakly not taken
	localparam logic [CTR_W-1:0] CTR_BRANCH_INIT = 2'b01;
	// jumps start strongly taken
	localparam logic [CTR_W-1:0] CTR_JUMP_INIT   = 2'b11;

	////////////////////
	// types
	////////////////////

	// one table line, 19 bits wide
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		logic [PC_W-1:0]  target;
		logic [CTR_W-1:0] ctr;
	} bht_entry_t;

	// compare type of the branch sitting in execute
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3,
		BR_GE   = 3'd4,
		BR_LTU  = 3'd5,
		BR_GEU  = 3'd6
	} br_type_e;

	// next-pc select from execute, msb set means override the fetch pc
	typedef enum logic [1:0] {
		CORR_NONE = 2'b00,
		CORR_CNI  = 2'b10,
		CORR_PBT  = 2'b11
	} corr_e;

endpackage

//--- bht_if.sv
`timescale 1ns/10ps

// combinational lookup port into the history table
interface bht_read_if import bp_pkg::*; ();

	// pc being looked up
	logic [PC_W-1:0]  pc;
	// exactly one valid way matched the tag
	logic             hit;
	logic [WAY_W-1:0] way;
	// matching line, all zeros on a miss
	bht_entry_t       entry;

	modport lookup (input pc, output hit, output way, output entry);
	modport client (output pc, input hit, input way, input entry);

endinterface

// single-cycle counter write strobe, lands on the next edge
interface bht_update_if import bp_pkg::*; ();

	logic             en;
	logic [SET_W-1:0] set;
	logic [WAY_W-1:0] way;
	logic [CTR_W-1:0] ctr;

	modport source (output en, output set, output way, output ctr);
	modport sink   (input en, input set, input way, input ctr);

endinterface

//--- bht_array.sv
`timescale 1ns/10ps

module bht_array import bp_pkg::*; (
	input  logic              CLK,
	input  logic              nrst,
	bht_read_if.lookup        if_rd,
	bht_read_if.lookup        exe_rd,
	input  logic [PC_W-1:0]   id_pc,
	input  logic [PC_W-1:0]   id_target,
	input  logic              id_is_btype,
	input  logic              id_is_jump,
	bht_update_if.sink        upd
);

	////////////////////
	// storage
	////////////////////

	// valid bits and fifo pointers are control state
	logic [SETS-1:0][WAYS-1:0]  valid_q;
	logic [SETS-1:0][WAY_W-1:0] fifo_ptr;

	// payload, only meaningful behind a valid bit
	logic [TAG_W-1:0] tag_mem [SETS][WAYS];
	logic [PC_W-1:0]  tgt_mem [SETS][WAYS];
	logic [CTR_W-1:0] ctr_mem [SETS][WAYS];

	// decode-stage lookup, used to decide on allocation
	bht_read_if id_rd ();

	logic             alloc;
	logic [SET_W-1:0] id_set;
	logic [WAY_W-1:0] alloc_way;

	////////////////////
	// lookup
	////////////////////

	// per-way tag compare within the set picked by pc
	function automatic logic [WAYS-1:0] match_ways(input logic [PC_W-1:0] pc);
		logic [WAYS-1:0]  m;
		logic [SET_W-1:0] s;
		s = pc[SET_W-1:0];
		for (int w = 0; w < WAYS; w++) begin
			m[w] = valid_q[s][w] && (tag_mem[s][w] == pc[PC_W-1:SET_W]);
		end
		return m;
	endfunction

	// shared by all three read ports
	function automatic void lookup(
		input  logic [PC_W-1:0]  pc,
		output logic             hit,
		output logic [WAY_W-1:0] way,
		output bht_entry_t       entry
	);
		logic [WAYS-1:0]  m;
		logic [SET_W-1:0] s;
		m     = match_ways(pc);
		s     = pc[SET_W-1:0];
		hit   = 1'b0;
		way   = '0;
		entry = '0;
		// a multi-way match is treated as a miss
		if ($onehot(m)) begin
			hit = 1'b1;
			for (int w = 0; w < WAYS; w++) begin
				if (m[w])
					way = w[WAY_W-1:0];
			end
			entry.valid  = 1'b1;
			entry.tag    = tag_mem[s][way];
			entry.target = tgt_mem[s][way];
			entry.ctr    = ctr_mem[s][way];
		end
	endfunction

	always_comb begin
		lookup(if_rd.pc, if_rd.hit, if_rd.way, if_rd.entry);
	end

	always_comb begin
		lookup(exe_rd.pc, exe_rd.hit, exe_rd.way, exe_rd.entry);
	end

	assign id_rd.pc = id_pc;

	always_comb begin
		lookup(id_rd.pc, id_rd.hit, id_rd.way, id_rd.entry);
	end

	////////////////////
	// allocation and counter writes
	////////////////////

	// only branches and jumps not already in the table get a line
	assign alloc     = (id_is_btype || id_is_jump) && !id_rd.hit;
	assign id_set    = id_pc[SET_W-1:0];
	assign alloc_way = fifo_ptr[id_set];

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			valid_q  <= '0;
			fifo_ptr <= '0;
		end else if (alloc) begin
			valid_q[id_set][alloc_way] <= 1'b1;
			// 2-bit pointer wraps from 3 back to 0 by itself
			fifo_ptr[id_set] <= alloc_way + 1'b1;
		end
	end

	// allocation has priority, a same-cycle counter update is dropped
	always_ff @(posedge CLK) begin
		if (alloc) begin
			tag_mem[id_set][alloc_way] <= id_pc[PC_W-1:SET_W];
			tgt_mem[id_set][alloc_way] <= id_target;
			ctr_mem[id_set][alloc_way] <= id_is_jump ? CTR_JUMP_INIT : CTR_BRANCH_INIT;
		end else if (upd.en) begin
			ctr_mem[upd.set][upd.way] <= upd.ctr;
		end
	end

	// freshly allocated pc must be found in exactly one way next cycle
	a_alloc_hits: assert property (@(posedge CLK) disable iff (!nrst)
		alloc |=> $onehot(match_ways($past(id_pc))));

endmodule

//--- branch_resolver.sv
`timescale 1ns/10ps

module branch_resolver import bp_pkg::*; (
	bht_read_if.client        exe_rd,
	input  logic [PC_W-1:0]   exe_pc,
	input  br_type_e          exe_btype,
	input  logic              exe_z,
	input  logic              exe_less,
	bht_update_if.source      upd,
	output logic              mispredict,
	output corr_e             exe_correction,
	output logic [PC_W-1:0]   exe_pbt,
	output logic [PC_W-1:0]   exe_cni
);

	logic             is_branch;
	logic             taken;
	logic             predicted;
	logic [CTR_W-1:0] ctr;
	logic [CTR_W-1:0] ctr_next;
	logic             at_limit;

	// table is looked up with the execute pc in the same cycle
	assign exe_rd.pc = exe_pc;

	////////////////////
	// outcome
	////////////////////

	// signed and unsigned compares differ only in the alu, not here
	always_comb begin
		case (exe_btype)
			BR_EQ:          taken = exe_z;
			BR_NE:          taken = !exe_z;
			BR_LT, BR_LTU:  taken = exe_less;
			BR_GE, BR_GEU:  taken = !exe_less;
			default:        taken = 1'b0;
		endcase
	end

	assign is_branch = (exe_btype != BR_NONE);

	// miss reads as a zero entry, so it predicts not taken
	assign ctr       = exe_rd.entry.ctr;
	assign predicted = ctr[CTR_W-1];

	////////////////////
	// correction
	////////////////////

	assign mispredict = is_branch && (taken != predicted);

	always_comb begin
		if (!mispredict)
			exe_correction = CORR_NONE;
		else if (taken)
			exe_correction = CORR_PBT;
		else
			exe_correction = CORR_CNI;
	end

	assign exe_pbt = exe_rd.entry.target;
	// fall-through address, word pc so plus one
	assign exe_cni = exe_pc + 1'b1;

	////////////////////
	// counter training
	////////////////////

	assign at_limit = taken ? (ctr == '1) : (ctr == '0);
	assign ctr_next = taken ? ctr + 1'b1 : ctr - 1'b1;

	// only a hit is trained, saturated counters need no write
	assign upd.en  = is_branch && exe_rd.hit && !at_limit;
	assign upd.set = exe_pc[SET_W-1:0];
	assign upd.way = exe_rd.way;
	assign upd.ctr = ctr_next;

endmodule

//--- flush_ctrl.sv
`timescale 1ns/10ps

module flush_ctrl import bp_pkg::*; (
	input  logic CLK,
	input  logic nrst,
	input  logic mispredict,
	input  logic id_is_jump,
	output logic flush
);

	// anything that redirects the front end
	logic       cause;
	// [0] one cycle after the cause, [1] two cycles after
	logic [1:0] hold_q;

	assign cause = mispredict || id_is_jump;

	always_ff @(posedge CLK) begin
		if (!nrst)
			hold_q <= '0;
		else
			hold_q <= {hold_q[0], cause};
	end

	// current misprediction flushes right away, jumps only from next cycle
	assign flush = mispredict || (|hold_q);

	// the hold stages come out of reset clear
	a_flush_reset: assert property (@(posedge CLK)
		$rose(nrst) |-> (flush == mispredict));

endmodule

//--- branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor import bp_pkg::*; (
	input  logic              CLK,
	input  logic              nrst,

	// fetch
	input  logic [PC_W-1:0]   if_pc,

	// decode
	input  logic [PC_W-1:0]   id_pc,
	input  logic [PC_W-1:0]   id_branchtarget,
	input  logic              id_is_jump,
	input  logic              id_is_btype,

	// execute, flags come from the alu
	input  logic [PC_W-1:0]   exe_pc,
	input  logic              exe_z,
	input  logic              exe_less,
	input  br_type_e          exe_btype,

	// to the next-pc mux
	output logic              if_prediction,
	output logic [PC_W-1:0]   if_pbt,
	output corr_e             exe_correction,
	output logic [PC_W-1:0]   exe_pbt,
	output logic [PC_W-1:0]   exe_cni,
	output logic              flush
);

	bht_read_if   if_rd ();
	bht_read_if   exe_rd ();
	bht_update_if upd ();

	logic mispredict;

	////////////////////
	// fetch side
	////////////////////

	assign if_rd.pc      = if_pc;
	// predict taken from the counter msb, zero on a miss
	assign if_prediction = if_rd.hit && if_rd.entry.ctr[CTR_W-1];
	assign if_pbt        = if_rd.entry.target;

	bht_array u_bht_array (
		.CLK         (CLK),
		.nrst        (nrst),
		.if_rd       (if_rd.lookup),
		.exe_rd      (exe_rd.lookup),
		.id_pc       (id_pc),
		.id_target   (id_branchtarget),
		.id_is_btype (id_is_btype),
		.id_is_jump  (id_is_jump),
		.upd         (upd.sink)
	);

	branch_resolver u_branch_resolver (
		.exe_rd         (exe_rd.client),
		.exe_pc         (exe_pc),
		.exe_btype      (exe_btype),
		.exe_z          (exe_z),
		.exe_less       (exe_less),
		.upd            (upd.source),
		.mispredict     (mispredict),
		.exe_correction (exe_correction),
		.exe_pbt        (exe_pbt),
		.exe_cni        (exe_cni)
	);

	flush_ctrl u_flush_ctrl (
		.CLK        (CLK),
		.nrst       (nrst),
		.mispredict (mispredict),
		.id_is_jump (id_is_jump),
		.flush      (flush)
	);

endmodule

//--- tb_clkgen.sv
`timescale 1ns/10ps

// free-running clock and power-on reset for the testbench
module tb_clkgen (
	output logic CLK,
	output logic nrst
);

	// 40 ns period
	localparam time HALF_PERIOD  = 20ns;
	localparam int  RESET_CYCLES = 5;

	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD) CLK = ~CLK;
	end

	// release lands 2 ns after an edge, like all other stimulus
	initial begin
		nrst = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2 nrst = 1'b1;
	end

endmodule

//--- tb_branch_predictor.sv
`timescale 1ns/10ps

module tb_branch_predictor import bp_pkg::*; ();

	// the tests take roughly 70 cycles, this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [PC_W-1:0] BR_PC   = 10'h123;
	localparam logic [PC_W-1:0] BR_TGT  = 10'h2a5;
	localparam logic [PC_W-1:0] JMP_PC  = 10'h045;
	localparam logic [PC_W-1:0] JMP_TGT = 10'h300;
	// expected fetch prediction per training cycle, bit i for cycle i
	localparam logic [5:0] TRAIN_PRED = 6'b011110;

	logic            CLK;
	logic            nrst;
	logic [PC_W-1:0] if_pc;
	logic [PC_W-1:0] id_pc;
	logic [PC_W-1:0] id_branchtarget;
	logic            id_is_jump;
	logic            id_is_btype;
	logic [PC_W-1:0] exe_pc;
	logic            exe_z;
	logic            exe_less;
	br_type_e        exe_btype;
	logic            if_prediction;
	logic [PC_W-1:0] if_pbt;
	corr_e           exe_correction;
	logic [PC_W-1:0] exe_pbt;
	logic [PC_W-1:0] exe_cni;
	logic            flush;

	////////////////////
	// reference model
	////////////////////

	logic             m_valid [SETS][WAYS];
	logic [TAG_W-1:0] m_tag [SETS][WAYS];
	logic [PC_W-1:0]  m_tgt [SETS][WAYS];
	logic [CTR_W-1:0] m_ctr [SETS][WAYS];
	logic [WAY_W-1:0] m_ptr [SETS];
	// flush causes of the last two cycles, [0] is the newest
	logic [1:0]       m_hold;
	// execute results of the current cycle, consumed at the edge
	logic             e_hit;
	logic [WAY_W-1:0] e_way;
	logic             e_taken;
	logic             e_mis;
	int               cycle_count = 0;
	int               error_count = 0;

	tb_clkgen u_clkgen (.CLK(CLK), .nrst(nrst));

	branch_predictor branch_predictor_i (
		.CLK(CLK), .nrst(nrst), .if_pc(if_pc), .id_pc(id_pc),
		.id_branchtarget(id_branchtarget), .id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype), .exe_pc(exe_pc), .exe_z(exe_z),
		.exe_less(exe_less), .exe_btype(exe_btype), .if_prediction(if_prediction),
		.if_pbt(if_pbt), .exe_correction(exe_correction), .exe_pbt(exe_pbt),
		.exe_cni(exe_cni), .flush(flush)
	);

	// hit only when exactly one valid way carries the tag
	function automatic logic model_hit(input logic [PC_W-1:0] pc, output logic [WAY_W-1:0] way);
		logic [SET_W-1:0] s;
		int               n;
		s   = pc[SET_W-1:0];
		n   = 0;
		way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == pc[PC_W-1:SET_W]) begin
				n++;
				way = WAY_W'(w);
			end
		end
		return n == 1;
	endfunction

	function automatic logic outcome(input br_type_e bt, input logic z, input logic less);
		case (bt)
			BR_EQ:         return z;
			BR_NE:         return !z;
			BR_LT, BR_LTU: return less;
			BR_GE, BR_GEU: return !less;
			default:       return 1'b0;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// every output against the model, for whatever is driven right now
	task automatic check_outputs(input string name);
		logic             f_hit;
		logic [WAY_W-1:0] f_way;
		logic [SET_W-1:0] fs;
		logic [SET_W-1:0] es;
		corr_e            corr;
		fs      = if_pc[SET_W-1:0];
		es      = exe_pc[SET_W-1:0];
		f_hit   = model_hit(if_pc, f_way);
		e_hit   = model_hit(exe_pc, e_way);
		e_taken = outcome(exe_btype, exe_z, exe_less);
		e_mis   = (exe_btype != BR_NONE) && (e_taken != (e_hit && m_ctr[es][e_way][1]));
		if (!e_mis)
			corr = CORR_NONE;
		else if (e_taken)
			corr = CORR_PBT;
		else
			corr = CORR_CNI;
		compare({name, " if_prediction"}, f_hit && m_ctr[fs][f_way][1], if_prediction);
		compare({name, " if_pbt"}, f_hit ? m_tgt[fs][f_way] : '0, if_pbt);
		compare({name, " exe_correction"}, corr, exe_correction);
		compare({name, " exe_pbt"}, e_hit ? m_tgt[es][e_way] : '0, exe_pbt);
		compare({name, " exe_cni"}, PC_W'(exe_pc + 1), exe_cni);
		compare({name, " flush"}, e_mis || (|m_hold), flush);
	endtask

	// check, then step the model across the edge and wait for the drive point
	task automatic next_cycle(input string name);
		logic             hit;
		logic [WAY_W-1:0] w;
		logic [SET_W-1:0] s;
		#1;
		check_outputs(name);
		@(posedge CLK);
		s   = id_pc[SET_W-1:0];
		hit = model_hit(id_pc, w);
		if ((id_is_btype || id_is_jump) && !hit) begin
			w             = m_ptr[s];
			m_valid[s][w] = 1'b1;
			m_tag[s][w]   = id_pc[PC_W-1:SET_W];
			m_tgt[s][w]   = id_branchtarget;
			m_ctr[s][w]   = id_is_jump ? 2'b11 : 2'b01;
			m_ptr[s]      = w + 1'b1;
		end else if (exe_btype != BR_NONE && e_hit) begin
			s = exe_pc[SET_W-1:0];
			if (e_taken && m_ctr[s][e_way] != 2'b11)
				m_ctr[s][e_way] = m_ctr[s][e_way] + 1'b1;
			else if (!e_taken && m_ctr[s][e_way] != 2'b00)
				m_ctr[s][e_way] = m_ctr[s][e_way] - 1'b1;
		end
		m_hold = {m_hold[0], e_mis || id_is_jump};
		#2;
	endtask

	task automatic idle_inputs();
		if_pc           = '0;
		id_pc           = '0;
		id_branchtarget = '0;
		id_is_jump      = 1'b0;
		id_is_btype     = 1'b0;
		exe_pc          = '0;
		exe_z           = 1'b0;
		exe_less        = 1'b0;
		exe_btype       = BR_NONE;
	endtask

	// three quiet cycles, flush must hold for the first high of them
	task automatic flush_tail(input string name, input int high);
		for (int k = 0; k < 3; k++) begin
			idle_inputs();
			#1;
			compare({name, " flush tail"}, k < high, flush);
			next_cycle(name);
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset_state();
		for (int i = 0; i < 8; i++) begin
			idle_inputs();
			if_pc  = PC_W'($urandom);
			exe_pc = PC_W'($urandom);
			#1;
			compare("reset_state if_prediction", 0, if_prediction);
			compare("reset_state if_pbt", 0, if_pbt);
			compare("reset_state exe_correction", CORR_NONE, exe_correction);
			compare("reset_state flush", 0, flush);
			next_cycle("reset_state");
		end
	endtask

	task automatic test_allocation();
		idle_inputs();
		id_pc           = BR_PC;
		id_branchtarget = BR_TGT;
		id_is_btype     = 1'b1;
		next_cycle("allocation");
		// jump goes in while the branch is read back
		idle_inputs();
		id_pc           = JMP_PC;
		id_branchtarget = JMP_TGT;
		id_is_jump      = 1'b1;
		if_pc           = BR_PC;
		#1;
		compare("allocation branch target", BR_TGT, if_pbt);
		compare("allocation branch prediction", 0, if_prediction);
		next_cycle("allocation");
		// first of the two flush cycles after the jump
		idle_inputs();
		if_pc = JMP_PC;
		#1;
		compare("allocation jump target", JMP_TGT, if_pbt);
		compare("allocation jump prediction", 1, if_prediction);
		compare("allocation jump flush", 1, flush);
		next_cycle("allocation");
		flush_tail("allocation", 1);
	endtask

	// three taken outcomes then two not taken on the branch at counter 01
	task automatic test_training();
		for (int i = 0; i < 6; i++) begin
			idle_inputs();
			if_pc = BR_PC;
			if (i < 5) begin
				exe_pc    = BR_PC;
				exe_btype = BR_EQ;
				exe_z     = (i < 3);
			end
			#1;
			compare("training if_prediction", TRAIN_PRED[i], if_prediction);
			next_cycle("training");
		end
	endtask

	task automatic test_mispredict();
		idle_inputs();
		exe_pc    = BR_PC;
		exe_btype = BR_NE;
		exe_z     = 1'b0;
		#1;
		compare("mispredict taken correction", CORR_PBT, exe_correction);
		compare("mispredict taken exe_pbt", BR_TGT, exe_pbt);
		compare("mispredict taken exe_cni", BR_PC + 1, exe_cni);
		compare("mispredict taken flush", 1, flush);
		next_cycle("mispredict");
		flush_tail("mispredict", 2);
		// counter now at 10, so a not-taken outcome is the reverse case
		idle_inputs();
		exe_pc    = BR_PC;
		exe_btype = BR_NE;
		exe_z     = 1'b1;
		#1;
		compare("mispredict not taken correction", CORR_CNI, exe_correction);
		compare("mispredict not taken exe_cni", BR_PC + 1, exe_cni);
		compare("mispredict not taken flush", 1, flush);
		next_cycle("mispredict");
		flush_tail("mispredict", 2);
	endtask

	// five tags into set 9, the fifth one evicts the first
	task automatic test_fifo();
		for (int k = 1; k <= 5; k++) begin
			idle_inputs();
			id_pc           = PC_W'(k * 16 + 9);
			id_branchtarget = PC_W'(10'h100 + k);
			id_is_btype     = 1'b1;
			next_cycle("fifo");
		end
		for (int k = 1; k <= 5; k++) begin
			idle_inputs();
			if_pc = PC_W'(k * 16 + 9);
			#1;
			compare("fifo target", (k == 1) ? 0 : 10'h100 + k, if_pbt);
			next_cycle("fifo");
		end
	endtask

	task automatic test_compare_types();
		for (int i = 0; i < 24; i++) begin
			idle_inputs();
			if_pc     = JMP_PC;
			exe_pc    = JMP_PC;
			exe_btype = br_type_e'(int'(BR_EQ) + i % 6);
			exe_z     = 1'($urandom);
			exe_less  = 1'($urandom);
			next_cycle("compare_types");
		end
	endtask

	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Simulation failed");
			$fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	initial begin
		void'($urandom(32'h7809_fa8f));
		m_hold = '0;
		for (int s = 0; s < SETS; s++) begin
			m_ptr[s] = '0;
			for (int w = 0; w < WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w]   = '0;
				m_tgt[s][w]   = '0;
				m_ctr[s][w]   = '0;
			end
		end
		idle_inputs();
		wait (nrst === 1'b1);
		@(posedge CLK);
		#2;
		test_reset_state();
		test_allocation();
		test_training();
		test_mispredict();
		test_fifo();
		test_compare_types();
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb.f
bp_pkg.sv
bht_if.sv
bht_array.sv
branch_resolver.sv
flush_ctrl.sv
branch_predictor.sv
tb_clkgen.sv
tb_branch_predictor.sv

//--- Bender.yml
package:
  name: branch_predictor

sources:
  - files:
      - bp_pkg.sv
      - bht_if.sv
      - bht_array.sv
      - branch_resolver.sv
      - flush_ctrl.sv
      - branch_predictor.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_branch_predictor.sv
